// ==== src/periph_pkg.sv ====
package periph_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus geometry and address map
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 12;
    localparam int OFS_W    = 8;
    localparam int REGION_W = ADDR_W - OFS_W;

    // Region is taken from the address bits above the register offset
    localparam logic [REGION_W-1:0] REGION_SOC_CTRL = 4'd0;
    localparam logic [REGION_W-1:0] REGION_TIMER    = 4'd1;
    localparam logic [REGION_W-1:0] REGION_EVENT    = 4'd2;

    localparam logic [OFS_W-1:0] OFS_BOOTADDR  = 8'h00;
    localparam logic [OFS_W-1:0] OFS_FETCHEN   = 8'h04;
    localparam logic [OFS_W-1:0] OFS_JTAG      = 8'h0C;
    localparam logic [OFS_W-1:0] OFS_TMR_CTRL  = 8'h00;
    localparam logic [OFS_W-1:0] OFS_TMR_COUNT = 8'h04;
    localparam logic [OFS_W-1:0] OFS_TMR_CMP   = 8'h08;
    localparam logic [OFS_W-1:0] OFS_EVT_MASK  = 8'h00;

    localparam logic [DATA_W-1:0] BOOTADDR_RESET = 32'h1C00_8080;

    ////////////////////////////////////////////////////////////////////////////
    // Peripheral sizing and interrupt lines
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_EVT        = 32;
    localparam int EVT_FIFO_DEPTH = 4;
    localparam int EVT_PTR_W      = $clog2(EVT_FIFO_DEPTH);
    localparam int EVT_ID_W       = 8;
    localparam int JTAG_W         = 8;
    localparam int IRQ_W          = 32;

    localparam int IRQ_DMA_EVT  = 8;
    localparam int IRQ_DMA_IRQ  = 9;
    localparam int IRQ_TIMER    = 10;
    localparam int IRQ_PF       = 12;
    localparam int IRQ_REF_EDGE = 14;

    typedef logic [DATA_W-1:0]   periph_data_t;
    typedef logic [ADDR_W-1:0]   periph_addr_t;
    typedef logic [OFS_W-1:0]    periph_ofs_t;
    typedef logic [EVT_ID_W-1:0] evt_id_t;
    typedef logic [IRQ_W-1:0]    irq_vec_t;

    typedef struct packed {
        periph_addr_t addr;
        logic         we;
        periph_data_t wdata;
    } periph_req_t;

    typedef struct packed {
        periph_data_t rdata;
        logic         err;
    } periph_rsp_t;

    // One access strobe per region plus the fields shared by all regions
    typedef struct packed {
        logic         strb_soc;
        logic         strb_tmr;
        logic         strb_evt;
        logic         we;
        periph_ofs_t  ofs;
        periph_data_t wdata;
    } periph_sel_t;

endpackage

// ==== src/periph_bus_ctrl.sv ====
`timescale 1ns/10ps

module periph_bus_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    req_i,
    input  periph_pkg::periph_req_t host_req_i,
    output logic                    ack_o,
    output periph_pkg::periph_rsp_t host_rsp_o,
    output periph_pkg::periph_sel_t sel_o,
    input  periph_pkg::periph_rsp_t soc_rsp_i,
    input  periph_pkg::periph_rsp_t tmr_rsp_i,
    input  periph_pkg::periph_rsp_t evt_rsp_i
);
    import periph_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_ACK,
        ST_WAIT_LOW
    } state_e;

    state_e              state_q;
    state_e              state_d;
    logic                start;
    logic [REGION_W-1:0] region;
    logic [REGION_W-1:0] region_q;
    // Strobe bits in the order {evt, tmr, soc}
    logic [2:0]          strb_d;
    logic [2:0]          strb_q;
    logic                we_q;
    periph_ofs_t         ofs_q;
    periph_data_t        wdata_q;
    periph_rsp_t         rsp_sel;
    periph_rsp_t         rsp_q;

    assign start  = (state_q == ST_IDLE) && req_i;
    assign region = host_req_i.addr[ADDR_W-1:OFS_W];

    always_comb begin
        case (region)
            REGION_SOC_CTRL: strb_d = 3'b001;
            REGION_TIMER:    strb_d = 3'b010;
            REGION_EVENT:    strb_d = 3'b100;
            default:         strb_d = 3'b000;
        endcase
    end

    // Four-phase handshake sequencing
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_i) begin
                    state_d = ST_ACCESS;
                end
            end
            ST_ACCESS:   state_d = ST_ACK;
            ST_ACK: begin
                if (!req_i) begin
                    state_d = ST_WAIT_LOW;
                end
            end
            ST_WAIT_LOW: state_d = ST_IDLE;
            default:     state_d = ST_IDLE;
        endcase
    end

    always_comb begin
        case (region_q)
            REGION_SOC_CTRL: rsp_sel = soc_rsp_i;
            REGION_TIMER:    rsp_sel = tmr_rsp_i;
            REGION_EVENT:    rsp_sel = evt_rsp_i;
            default:         rsp_sel = '{rdata: '0, err: 1'b1};
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            strb_q  <= '0;
        end else begin
            state_q <= state_d;
            // Strobe lives for exactly the access cycle
            strb_q  <= start ? strb_d : 3'b000;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            region_q <= region;
            we_q     <= host_req_i.we;
            ofs_q    <= host_req_i.addr[OFS_W-1:0];
            wdata_q  <= host_req_i.wdata;
        end
        if (state_q == ST_ACCESS) begin
            rsp_q <= rsp_sel;
        end
    end

    assign sel_o.strb_soc = strb_q[0];
    assign sel_o.strb_tmr = strb_q[1];
    assign sel_o.strb_evt = strb_q[2];
    assign sel_o.we       = we_q;
    assign sel_o.ofs      = ofs_q;
    assign sel_o.wdata    = wdata_q;

    assign ack_o      = (state_q == ST_ACK) || (state_q == ST_WAIT_LOW);
    assign host_rsp_o = rsp_q;

endmodule

// ==== src/soc_ctrl_regs.sv ====
`timescale 1ns/10ps

module soc_ctrl_regs (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  periph_pkg::periph_sel_t         sel_i,
    output periph_pkg::periph_rsp_t         rsp_o,
    input  logic                            fc_fetch_en_valid_i,
    input  logic                            fc_fetch_en_i,
    input  logic [periph_pkg::JTAG_W-1:0]   soc_jtag_reg_i,
    output periph_pkg::periph_data_t        fc_bootaddr_o,
    output logic                            fc_fetchen_o,
    output logic [periph_pkg::JTAG_W-1:0]   soc_jtag_reg_o
);
    import periph_pkg::*;

    periph_data_t      bootaddr_q;
    logic              fetchen_q;
    logic [JTAG_W-1:0] jtag_q;
    logic              wr;

    assign wr = sel_i.strb_soc && sel_i.we;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bootaddr_q <= BOOTADDR_RESET;
            fetchen_q  <= 1'b0;
            jtag_q     <= '0;
        end else begin
            if (wr && sel_i.ofs == OFS_BOOTADDR) begin
                bootaddr_q <= sel_i.wdata;
            end
            // External fetch enable wins over a bus write
            if (fc_fetch_en_valid_i) begin
                fetchen_q <= fc_fetch_en_i;
            end else if (wr && sel_i.ofs == OFS_FETCHEN) begin
                fetchen_q <= sel_i.wdata[0];
            end
            if (wr && sel_i.ofs == OFS_JTAG) begin
                jtag_q <= sel_i.wdata[JTAG_W-1:0];
            end
        end
    end

    always_comb begin
        rsp_o = '{rdata: '0, err: 1'b0};
        case (sel_i.ofs)
            OFS_BOOTADDR: rsp_o.rdata = bootaddr_q;
            OFS_FETCHEN:  rsp_o.rdata = {{(DATA_W-1){1'b0}}, fetchen_q};
            OFS_JTAG:     rsp_o.rdata = {{(DATA_W-JTAG_W){1'b0}}, soc_jtag_reg_i};
            default:      rsp_o.err   = 1'b1;
        endcase
    end

    assign fc_bootaddr_o  = bootaddr_q;
    assign fc_fetchen_o   = fetchen_q;
    assign soc_jtag_reg_o = jtag_q;

endmodule

// ==== src/soc_timer.sv ====
`timescale 1ns/10ps

module soc_timer (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  periph_pkg::periph_sel_t sel_i,
    output periph_pkg::periph_rsp_t rsp_o,
    output logic                    irq_o
);
    import periph_pkg::*;

    logic         en_q;
    periph_data_t count_q;
    periph_data_t cmp_q;
    logic         irq_q;
    logic         wr;
    logic         hit;

    assign wr  = sel_i.strb_tmr && sel_i.we;
    assign hit = en_q && (count_q == cmp_q);

    ////////////////////////////////////////////////////////////////////////////
    // Counter with compare
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            en_q    <= 1'b0;
            count_q <= '0;
            cmp_q   <= '0;
            irq_q   <= 1'b0;
        end else begin
            if (wr && sel_i.ofs == OFS_TMR_CTRL) begin
                en_q <= sel_i.wdata[0];
            end
            if (wr && sel_i.ofs == OFS_TMR_CMP) begin
                cmp_q <= sel_i.wdata;
            end
            // Bus write beats both the wrap and the increment
            if (wr && sel_i.ofs == OFS_TMR_COUNT) begin
                count_q <= sel_i.wdata;
            end else if (hit) begin
                count_q <= '0;
            end else if (en_q) begin
                count_q <= count_q + 1'b1;
            end
            irq_q <= hit;
        end
    end

    always_comb begin
        rsp_o = '{rdata: '0, err: 1'b0};
        case (sel_i.ofs)
            OFS_TMR_CTRL:  rsp_o.rdata = {{(DATA_W-1){1'b0}}, en_q};
            OFS_TMR_COUNT: rsp_o.rdata = count_q;
            OFS_TMR_CMP:   rsp_o.rdata = cmp_q;
            default:       rsp_o.err   = 1'b1;
        endcase
    end

    assign irq_o = irq_q;

endmodule

// ==== src/event_router.sv ====
`timescale 1ns/10ps

module event_router (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  periph_pkg::periph_sel_t          sel_i,
    output periph_pkg::periph_rsp_t          rsp_o,
    input  logic [periph_pkg::NUM_EVT-1:0]   events_i,
    output logic                             fc_event_valid_o,
    output periph_pkg::evt_id_t              fc_event_data_o,
    input  logic                             fc_event_ready_i
);
    import periph_pkg::*;

    logic [NUM_EVT-1:0] mask_q;
    logic [NUM_EVT-1:0] pending_q;
    logic [NUM_EVT-1:0] clr;
    logic               pick_valid;
    evt_id_t            pick_idx;

    evt_id_t            fifo_q [EVT_FIFO_DEPTH];
    logic [EVT_PTR_W:0] wptr_q;
    logic [EVT_PTR_W:0] rptr_q;
    logic               full;
    logic               empty;
    logic               push;
    logic               pop;

    // Lowest-numbered pending line wins
    always_comb begin
        pick_valid = 1'b0;
        pick_idx   = '0;
        for (int i = NUM_EVT - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                pick_valid = 1'b1;
                pick_idx   = evt_id_t'(i);
            end
        end
    end

    assign empty = (wptr_q == rptr_q);
    assign full  = (wptr_q[EVT_PTR_W] != rptr_q[EVT_PTR_W]) &&
                   (wptr_q[EVT_PTR_W-1:0] == rptr_q[EVT_PTR_W-1:0]);
    assign push  = pick_valid && !full;
    assign pop   = !empty && fc_event_ready_i;
    assign clr   = push ? (NUM_EVT'(1) << pick_idx) : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Mask, pending latch and FIFO pointers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q    <= '0;
            pending_q <= '0;
            wptr_q    <= '0;
            rptr_q    <= '0;
        end else begin
            if (sel_i.strb_evt && sel_i.we && sel_i.ofs == OFS_EVT_MASK) begin
                mask_q <= sel_i.wdata;
            end
            // A pulse on an already pending line folds into that event
            pending_q <= (pending_q & ~clr) | (events_i & mask_q);
            if (push) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= rptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_q[wptr_q[EVT_PTR_W-1:0]] <= pick_idx;
        end
    end

    always_comb begin
        rsp_o = '{rdata: '0, err: 1'b0};
        if (sel_i.ofs == OFS_EVT_MASK) begin
            rsp_o.rdata = mask_q;
        end else begin
            rsp_o.err = 1'b1;
        end
    end

    assign fc_event_valid_o = !empty;
    assign fc_event_data_o  = fifo_q[rptr_q[EVT_PTR_W-1:0]];

endmodule

// ==== src/irq_mapper.sv ====
`timescale 1ns/10ps

module irq_mapper (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 slow_clk_i,
    input  logic                 tmr_irq_i,
    input  logic                 dma_pe_evt_i,
    input  logic                 dma_pe_irq_i,
    input  logic                 pf_evt_i,
    output periph_pkg::irq_vec_t fc_interrupts_o
);
    import periph_pkg::*;

    logic [1:0] sync_q;
    logic       edge_q;
    logic       ref_pulse_q;

    // Bring the reference clock in and flag both of its edges
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sync_q      <= '0;
            edge_q      <= 1'b0;
            ref_pulse_q <= 1'b0;
        end else begin
            sync_q      <= {sync_q[0], slow_clk_i};
            edge_q      <= sync_q[1];
            ref_pulse_q <= sync_q[1] ^ edge_q;
        end
    end

    always_comb begin
        fc_interrupts_o               = '0;
        fc_interrupts_o[IRQ_DMA_EVT]  = dma_pe_evt_i;
        fc_interrupts_o[IRQ_DMA_IRQ]  = dma_pe_irq_i;
        fc_interrupts_o[IRQ_TIMER]    = tmr_irq_i;
        fc_interrupts_o[IRQ_PF]       = pf_evt_i;
        fc_interrupts_o[IRQ_REF_EDGE] = ref_pulse_q;
    end

endmodule

// ==== src/soc_periph_top.sv ====
`timescale 1ns/10ps

module soc_periph_top (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            slow_clk_i,
    input  logic                            req_i,
    input  periph_pkg::periph_req_t         host_req_i,
    output logic                            ack_o,
    output periph_pkg::periph_rsp_t         host_rsp_o,
    input  logic                            fc_fetch_en_valid_i,
    input  logic                            fc_fetch_en_i,
    input  logic [periph_pkg::JTAG_W-1:0]   soc_jtag_reg_i,
    output logic [periph_pkg::JTAG_W-1:0]   soc_jtag_reg_o,
    output periph_pkg::periph_data_t        fc_bootaddr_o,
    output logic                            fc_fetchen_o,
    input  logic [periph_pkg::NUM_EVT-1:0]  events_i,
    output logic                            fc_event_valid_o,
    output periph_pkg::evt_id_t             fc_event_data_o,
    input  logic                            fc_event_ready_i,
    input  logic                            dma_pe_evt_i,
    input  logic                            dma_pe_irq_i,
    input  logic                            pf_evt_i,
    output periph_pkg::irq_vec_t            fc_interrupts_o
);
    import periph_pkg::*;

    periph_sel_t sel;
    periph_rsp_t soc_rsp;
    periph_rsp_t tmr_rsp;
    periph_rsp_t evt_rsp;
    logic        tmr_irq;

    periph_bus_ctrl i_bus_ctrl (
        .clk_i      ( clk_i      ),
        .rst_ni     ( rst_ni     ),
        .req_i      ( req_i      ),
        .host_req_i ( host_req_i ),
        .ack_o      ( ack_o      ),
        .host_rsp_o ( host_rsp_o ),
        .sel_o      ( sel        ),
        .soc_rsp_i  ( soc_rsp    ),
        .tmr_rsp_i  ( tmr_rsp    ),
        .evt_rsp_i  ( evt_rsp    )
    );

    soc_ctrl_regs i_soc_ctrl (
        .clk_i               ( clk_i               ),
        .rst_ni              ( rst_ni              ),
        .sel_i               ( sel                 ),
        .rsp_o               ( soc_rsp             ),
        .fc_fetch_en_valid_i ( fc_fetch_en_valid_i ),
        .fc_fetch_en_i       ( fc_fetch_en_i       ),
        .soc_jtag_reg_i      ( soc_jtag_reg_i      ),
        .fc_bootaddr_o       ( fc_bootaddr_o       ),
        .fc_fetchen_o        ( fc_fetchen_o        ),
        .soc_jtag_reg_o      ( soc_jtag_reg_o      )
    );

    soc_timer i_timer (
        .clk_i  ( clk_i   ),
        .rst_ni ( rst_ni  ),
        .sel_i  ( sel     ),
        .rsp_o  ( tmr_rsp ),
        .irq_o  ( tmr_irq )
    );

    event_router i_event_router (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .sel_i            ( sel              ),
        .rsp_o            ( evt_rsp          ),
        .events_i         ( events_i         ),
        .fc_event_valid_o ( fc_event_valid_o ),
        .fc_event_data_o  ( fc_event_data_o  ),
        .fc_event_ready_i ( fc_event_ready_i )
    );

    irq_mapper i_irq_mapper (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .slow_clk_i      ( slow_clk_i      ),
        .tmr_irq_i       ( tmr_irq         ),
        .dma_pe_evt_i    ( dma_pe_evt_i    ),
        .dma_pe_irq_i    ( dma_pe_irq_i    ),
        .pf_evt_i        ( pf_evt_i        ),
        .fc_interrupts_o ( fc_interrupts_o )
    );

endmodule

// ==== sim/soc_periph_checker.sv ====
`timescale 1ns/10ps

module soc_periph_checker (
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic                    req_i,
    input logic                    ack_i,
    input periph_pkg::periph_sel_t sel_i,
    input logic                    evt_valid_i,
    input periph_pkg::evt_id_t     evt_data_i,
    input logic                    evt_ready_i
);

    logic [2:0] strobes;

    assign strobes = {sel_i.strb_evt, sel_i.strb_tmr, sel_i.strb_soc};

    ////////////////////////////////////////////////////////////////////////////
    // Host handshake and region decode
    ////////////////////////////////////////////////////////////////////////////

    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(ack_i) |-> req_i)
        else $error("ack_o rose while req_i was low");

    strobe_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(strobes))
        else $error("More than one region strobe active");

    // Event port holds its offer until taken
    evt_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        evt_valid_i && !evt_ready_i |=> evt_valid_i && $stable(evt_data_i))
        else $error("Event valid or data changed before ready");

endmodule

bind soc_periph_top soc_periph_checker i_checker (
    .clk_i       ( clk_i            ),
    .rst_ni      ( rst_ni           ),
    .req_i       ( req_i            ),
    .ack_i       ( ack_o            ),
    .sel_i       ( sel              ),
    .evt_valid_i ( fc_event_valid_o ),
    .evt_data_i  ( fc_event_data_o  ),
    .evt_ready_i ( fc_event_ready_i )
);

// ==== sim/tb_soc_periph.sv ====
`timescale 1ns/10ps

module tb_soc_periph;
    import periph_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int TMR_CMP_VAL    = 6;
    localparam int EVT_ROUNDS     = 8;

    logic               clk_i;
    logic               rst_ni;
    logic               slow_clk_i;
    logic               req_i;
    periph_req_t        host_req_i;
    logic               ack_o;
    periph_rsp_t        host_rsp_o;
    logic               fc_fetch_en_valid_i;
    logic               fc_fetch_en_i;
    logic [JTAG_W-1:0]  soc_jtag_reg_i;
    logic [JTAG_W-1:0]  soc_jtag_reg_o;
    periph_data_t       fc_bootaddr_o;
    logic               fc_fetchen_o;
    logic [NUM_EVT-1:0] events_i;
    logic               fc_event_valid_o;
    evt_id_t            fc_event_data_o;
    logic               fc_event_ready_i;
    logic               dma_pe_evt_i;
    logic               dma_pe_irq_i;
    logic               pf_evt_i;
    irq_vec_t           fc_interrupts_o;
    int                 seed;

    soc_periph_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at %0t", $time);
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        stop_with_failure();
    endtask

    task automatic check_data(input string name, input periph_data_t got,
                              input periph_data_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_evt(input string name, input evt_id_t got, input evt_id_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_irq(input string name, input irq_vec_t got, input irq_vec_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Host bus access
    ////////////////////////////////////////////////////////////////////////////

    function automatic periph_addr_t reg_addr(input logic [REGION_W-1:0] region,
                                              input periph_ofs_t ofs);
        return {region, ofs};
    endfunction

    // Raise req, wait for ack, drop req and wait for ack low
    task automatic run_handshake(input periph_req_t req, output periph_rsp_t rsp);
        int n;
        @(posedge clk_i);
        host_req_i <= req;
        req_i      <= 1'b1;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT_CYCLES) stop_on_timeout("ack_o to rise");
        end while (!ack_o);
        rsp = host_rsp_o;
        @(posedge clk_i);
        req_i <= 1'b0;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT_CYCLES) stop_on_timeout("ack_o to fall");
        end while (ack_o);
    endtask

    task automatic bus_write(input periph_addr_t addr, input periph_data_t data);
        periph_rsp_t rsp;
        run_handshake('{addr: addr, we: 1'b1, wdata: data}, rsp);
        check_flag("host_rsp_o.err", rsp.err, 1'b0);
    endtask

    task automatic bus_read(input periph_addr_t addr, output periph_rsp_t rsp);
        run_handshake('{addr: addr, we: 1'b0, wdata: '0}, rsp);
    endtask

    task automatic expect_error_read(input periph_addr_t addr);
        periph_rsp_t rsp;
        bus_read(addr, rsp);
        check_flag("host_rsp_o.err", rsp.err, 1'b1);
        check_data("host_rsp_o.rdata", rsp.rdata, '0);
    endtask

    task automatic expect_error_write(input periph_addr_t addr, input periph_data_t data);
        periph_rsp_t rsp;
        run_handshake('{addr: addr, we: 1'b1, wdata: data}, rsp);
        check_flag("host_rsp_o.err", rsp.err, 1'b1);
        check_data("host_rsp_o.rdata", rsp.rdata, '0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        periph_rsp_t rsp;
        @(negedge clk_i);
        check_flag("ack_o", ack_o, 1'b0);
        check_flag("fc_event_valid_o", fc_event_valid_o, 1'b0);
        check_flag("fc_fetchen_o", fc_fetchen_o, 1'b0);
        check_irq("fc_interrupts_o", fc_interrupts_o, '0);
        check_data("soc_jtag_reg_o", periph_data_t'(soc_jtag_reg_o), '0);
        check_data("fc_bootaddr_o", fc_bootaddr_o, BOOTADDR_RESET);
        bus_read(reg_addr(REGION_SOC_CTRL, OFS_BOOTADDR), rsp);
        check_flag("host_rsp_o.err", rsp.err, 1'b0);
        check_data("host_rsp_o.rdata", rsp.rdata, BOOTADDR_RESET);
    endtask

    task automatic test_soc_ctrl();
        periph_rsp_t rsp;
        bus_write(reg_addr(REGION_SOC_CTRL, OFS_BOOTADDR), 32'h1C00_0100);
        @(negedge clk_i);
        check_data("fc_bootaddr_o", fc_bootaddr_o, 32'h1C00_0100);
        bus_read(reg_addr(REGION_SOC_CTRL, OFS_BOOTADDR), rsp);
        check_data("host_rsp_o.rdata", rsp.rdata, 32'h1C00_0100);

        bus_write(reg_addr(REGION_SOC_CTRL, OFS_FETCHEN), 32'h1);
        @(negedge clk_i);
        check_flag("fc_fetchen_o", fc_fetchen_o, 1'b1);
        // External override held through a bus write of the same register
        @(posedge clk_i);
        fc_fetch_en_valid_i <= 1'b1;
        fc_fetch_en_i       <= 1'b0;
        bus_write(reg_addr(REGION_SOC_CTRL, OFS_FETCHEN), 32'h1);
        @(posedge clk_i);
        fc_fetch_en_valid_i <= 1'b0;
        @(negedge clk_i);
        check_flag("fc_fetchen_o", fc_fetchen_o, 1'b0);
        bus_read(reg_addr(REGION_SOC_CTRL, OFS_FETCHEN), rsp);
        check_data("host_rsp_o.rdata", rsp.rdata, 32'h0);

        bus_write(reg_addr(REGION_SOC_CTRL, OFS_JTAG), 32'h0000_00A5);
        @(negedge clk_i);
        check_data("soc_jtag_reg_o", periph_data_t'(soc_jtag_reg_o), 32'hA5);
        @(posedge clk_i);
        soc_jtag_reg_i <= 8'h3C;
        bus_read(reg_addr(REGION_SOC_CTRL, OFS_JTAG), rsp);
        check_data("host_rsp_o.rdata", rsp.rdata, 32'h3C);
    endtask

    task automatic test_decode();
        expect_error_read(reg_addr(4'hF, 8'h00));
        expect_error_read(reg_addr(4'd3, 8'h04));
        expect_error_read(reg_addr(REGION_SOC_CTRL, 8'h08));
        expect_error_read(reg_addr(REGION_TIMER, 8'h0C));
        expect_error_read(reg_addr(REGION_EVENT, 8'h04));
        expect_error_write(reg_addr(4'hF, 8'h00), 32'hDEAD_BEEF);
        expect_error_write(reg_addr(REGION_SOC_CTRL, 8'h08), 32'hFFFF_FFFF);
        @(negedge clk_i);
        // Registers keep what test_soc_ctrl left in them
        check_data("fc_bootaddr_o", fc_bootaddr_o, 32'h1C00_0100);
        check_flag("fc_fetchen_o", fc_fetchen_o, 1'b0);
        check_data("soc_jtag_reg_o", periph_data_t'(soc_jtag_reg_o), 32'hA5);
    endtask

    task automatic wait_timer_pulse(output int cycles);
        int n;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT_CYCLES) stop_on_timeout("the timer interrupt");
        end while (!fc_interrupts_o[IRQ_TIMER]);
        cycles = n;
    endtask

    task automatic test_timer();
        periph_rsp_t rsp;
        int          gap;
        bus_write(reg_addr(REGION_TIMER, OFS_TMR_CMP), TMR_CMP_VAL);
        bus_write(reg_addr(REGION_TIMER, OFS_TMR_CTRL), 32'h1);
        // First pulse only aligns the interval count
        wait_timer_pulse(gap);
        check_irq("fc_interrupts_o", fc_interrupts_o, irq_vec_t'(1) << IRQ_TIMER);
        repeat (3) begin
            wait_timer_pulse(gap);
            if (gap != TMR_CMP_VAL + 1) begin
                $display("Timer pulses came %0d cycles apart instead of %0d",
                         gap, TMR_CMP_VAL + 1);
                stop_with_failure();
            end
        end
        bus_write(reg_addr(REGION_TIMER, OFS_TMR_CTRL), 32'h0);
        bus_read(reg_addr(REGION_TIMER, OFS_TMR_COUNT), rsp);
        if (rsp.rdata > TMR_CMP_VAL) begin
            $display("Timer count 0x%h went past the compare value", rsp.rdata);
            stop_with_failure();
        end
    endtask

    // Ids arrive in ascending order while ready stalls at random
    task automatic collect_events(input logic [NUM_EVT-1:0] fired);
        evt_id_t     exp_q[$];
        int          got;
        int          n;
        logic [31:0] rnd;
        for (int i = 0; i < NUM_EVT; i++) begin
            if (fired[i]) exp_q.push_back(evt_id_t'(i));
        end
        got = 0;
        n   = 0;
        while (got < exp_q.size()) begin
            @(posedge clk_i);
            rnd = $random(seed);
            fc_event_ready_i <= rnd[0];
            @(negedge clk_i);
            if (fc_event_valid_o && fc_event_ready_i) begin
                check_evt("fc_event_data_o", fc_event_data_o, exp_q[got]);
                got++;
            end
            n++;
            if (n > TIMEOUT_CYCLES) stop_on_timeout("an event id");
        end
        @(posedge clk_i);
        fc_event_ready_i <= 1'b0;
        // Nothing more may show up
        repeat (8) begin
            @(negedge clk_i);
            check_flag("fc_event_valid_o", fc_event_valid_o, 1'b0);
        end
    endtask

    task automatic test_events();
        logic [NUM_EVT-1:0] mask;
        logic [NUM_EVT-1:0] pattern;
        periph_rsp_t        rsp;
        mask = $random(seed);
        bus_write(reg_addr(REGION_EVENT, OFS_EVT_MASK), mask);
        bus_read(reg_addr(REGION_EVENT, OFS_EVT_MASK), rsp);
        check_data("host_rsp_o.rdata", rsp.rdata, mask);
        for (int r = 0; r < EVT_ROUNDS; r++) begin
            pattern = $random(seed);
            // last round pulses every line to keep the FIFO full
            if (r == EVT_ROUNDS - 1) pattern = {NUM_EVT{1'b1}};
            @(posedge clk_i);
            events_i <= pattern;
            @(posedge clk_i);
            events_i <= '0;
            collect_events(pattern & mask);
        end
    endtask

    task automatic test_irq_vec();
        irq_vec_t exp;
        int       n;
        for (int e = 0; e < 4; e++) begin
            @(posedge clk_i);
            slow_clk_i <= ~slow_clk_i;
            n = 0;
            do begin
                @(negedge clk_i);
                n++;
                if (n > 4) begin
                    $display("No reference edge interrupt within 4 cycles of edge %0d", e);
                    stop_with_failure();
                end
            end while (!fc_interrupts_o[IRQ_REF_EDGE]);
            check_irq("fc_interrupts_o", fc_interrupts_o, irq_vec_t'(1) << IRQ_REF_EDGE);
            @(negedge clk_i);
            check_irq("fc_interrupts_o", fc_interrupts_o, '0);
            repeat (4) @(posedge clk_i);
        end
        // Pass-through lines in every combination
        for (int k = 0; k < 8; k++) begin
            @(posedge clk_i);
            dma_pe_evt_i <= k[0];
            dma_pe_irq_i <= k[1];
            pf_evt_i     <= k[2];
            exp              = '0;
            exp[IRQ_DMA_EVT] = k[0];
            exp[IRQ_DMA_IRQ] = k[1];
            exp[IRQ_PF]      = k[2];
            @(negedge clk_i);
            check_irq("fc_interrupts_o", fc_interrupts_o, exp);
        end
    endtask

    initial begin
        seed                = 44;
        rst_ni              = 1'b0;
        slow_clk_i          = 1'b0;
        req_i               = 1'b0;
        host_req_i          = '0;
        fc_fetch_en_valid_i = 1'b0;
        fc_fetch_en_i       = 1'b0;
        soc_jtag_reg_i      = '0;
        events_i            = '0;
        fc_event_ready_i    = 1'b0;
        dma_pe_evt_i        = 1'b0;
        dma_pe_irq_i        = 1'b0;
        pf_evt_i            = 1'b0;
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;

        test_reset_state();
        test_soc_ctrl();
        test_decode();
        test_timer();
        test_events();
        test_irq_vec();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== build.f ====
src/periph_pkg.sv
src/periph_bus_ctrl.sv
src/soc_ctrl_regs.sv
src/soc_timer.sv
src/event_router.sv
src/irq_mapper.sv
src/soc_periph_top.sv
sim/soc_periph_checker.sv
sim/tb_soc_periph.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_soc_periph
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
BIN       ?= V$(TOP)
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(BIN)

run: compile
	@out="$$(./$(OBJ_DIR)/$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
